// ==== tb.f ====
logic/iigs_pkg.sv
logic/bus_map.sv
logic/soft_switches.sv
logic/irq_ctrl.sv
logic/iigs_glue.sv
+incdir+include
tests/tb_iigs_glue.sv

// ==== include/glue_tests.svh ====
`ifndef GLUE_TESTS_SVH
`define GLUE_TESTS_SVH

// one cpu_ce cycle on the C0xx page of bank 00
task automatic io_write(input io_reg_t ofs, input byte_t data);
  @(posedge clk_sys);
  #1;
  cpu_addr = {BANK_00, 8'hC0, ofs};
  cpu_rd   = 1'b0;
  cpu_dout = data;
  cpu_ce   = 1'b1;
  @(posedge clk_sys);
  #1;
  cpu_ce   = 1'b0;
  cpu_rd   = 1'b1;
  cpu_addr = IDLE_ADDR;
endtask

task automatic io_read(input io_reg_t ofs, output byte_t data);
  @(posedge clk_sys);
  #1;
  cpu_addr = {BANK_00, 8'hC0, ofs};
  cpu_rd   = 1'b1;
  cpu_ce   = 1'b1;
  @(posedge clk_sys);
  #1;
  cpu_ce   = 1'b0;
  compare_value("io", io, 1'b1);  // bank 00 C0xx with shadow bit 6 clear
  data     = cpu_din;  // address still on the I/O page
  cpu_addr = IDLE_ADDR;
endtask

task automatic read_expect(input io_reg_t ofs, input byte_t exp);
  byte_t got;
  io_read(ofs, got);
  compare_value($sformatf("cpu_din at C0%h", ofs), got, exp);
endtask

task automatic map_check(input cpu_addr_t addr, input logic rd, input cpu_addr_t exp);
  @(posedge clk_sys);
  #1;
  cpu_addr = addr;
  cpu_rd   = rd;
  #10;
  compare_value($sformatf("bus_addr for %h rd %0d", addr, rd), bus_addr, exp);
endtask

// aux bits for pages 00, 04, 20, 80 from msb down
task automatic check_pages(input logic rd, input logic [3:0] aux);
  logic [15:0] ofs [4];
  cpu_addr_t   exp;
  ofs[0] = 16'h0012;
  ofs[1] = 16'h0412;
  ofs[2] = 16'h2012;
  ofs[3] = 16'h8012;
  for (int i = 0; i < 4; i++) begin
    exp = {BANK_00, ofs[i]} + (aux[3-i] ? AUX_OFFSET : 24'h0);
    map_check({BANK_00, ofs[i]}, rd, exp);
    map_check({8'h02, ofs[i]}, rd, {8'h02, ofs[i]});  // bank 02 never moves
  end
endtask

// {scanline, onesecond, qtrsecond, vbl}, high for one clock
task automatic pulse_irq(input logic [3:0] mask);
  @(posedge clk_sys);
  #1;
  {scanline_irq, onesecond_irq, qtrsecond_irq, vbl_irq} = mask;
  @(posedge clk_sys);
  #1;
  {scanline_irq, onesecond_irq, qtrsecond_irq, vbl_irq} = 4'b0000;
endtask

task automatic clear_switches();
  byte_t got;
  io_write(STORE80_OFF, 8'h00);
  io_write(RAMRD_OFF, 8'h00);
  io_write(RAMWRT_OFF, 8'h00);
  io_write(ALTZP_OFF, 8'h00);
  io_read(PAGE2_CLR, got);
  io_read(HIRES_CLR, got);
endtask

task automatic test_reset_defaults();
  compare_value("io", io, 1'b0);
  compare_value("cpu_irq", cpu_irq, 1'b0);
  compare_value("lc_we", lc_we, 1'b0);
  compare_value("lcram2", lcram2, 1'b0);
  compare_value("rdrom", rdrom, 1'b1);
  compare_value("textg", textg, 1'b0);
  compare_value("mixg", mixg, 1'b0);
  compare_value("page2", page2, 1'b0);
  compare_value("hires_mode", hires_mode, 1'b0);
  compare_value("shadow", shadow, 8'h08);
  compare_value("newvideo", newvideo, 8'h41);
  compare_value("textcolor", textcolor, 8'hF2);
  read_expect(SHADOW, 8'h08);
  read_expect(NEWVIDEO, 8'h41);
  read_expect(TEXTCOLOR, 8'hF2);
  read_expect(STATEREG, 8'h08);  // only rdrom
endtask

task automatic test_switches();
  byte_t got;
  byte_t data;
  io_write(STORE80_ON, 8'h00);
  io_write(RAMRD_ON, 8'h00);
  io_read(TXT_SET, got);
  io_read(PAGE2_SET, got);
  io_read(HIRES_SET, got);
  compare_value("textg", textg, 1'b1);
  compare_value("page2", page2, 1'b1);
  compare_value("hires_mode", hires_mode, 1'b1);
  read_expect(8'h18, 8'h80);  // 80STORE
  read_expect(8'h13, 8'h80);  // RAMRD
  read_expect(8'h14, 8'h00);  // RAMWRT untouched
  read_expect(8'h1A, 8'h80);  // TEXT
  read_expect(8'h1C, 8'h80);  // PAGE2
  read_expect(8'h1D, 8'h80);  // HIRES
  read_expect(8'h19, 8'h80);  // vblank low
  rng_state = xorshift(rng_state);
  data = rng_state[7:0];
  io_write(NEWVIDEO, data);
  compare_value("newvideo", newvideo, data);
  read_expect(NEWVIDEO, data);
endtask

task automatic test_aux_map();
  byte_t got;
  clear_switches();
  check_pages(1'b1, 4'b0000);
  io_write(ALTZP_ON, 8'h00);
  check_pages(1'b1, 4'b1000);
  io_write(ALTZP_OFF, 8'h00);
  io_write(RAMRD_ON, 8'h00);
  check_pages(1'b1, 4'b0111);
  check_pages(1'b0, 4'b0000);
  io_write(RAMRD_OFF, 8'h00);
  io_write(RAMWRT_ON, 8'h00);
  check_pages(1'b0, 4'b0111);
  check_pages(1'b1, 4'b0000);
  // 80STORE with PAGE2 takes over the text page
  io_write(STORE80_ON, 8'h00);
  io_read(PAGE2_SET, got);
  check_pages(1'b1, 4'b0100);
  check_pages(1'b0, 4'b0111);
  io_read(HIRES_SET, got);
  check_pages(1'b1, 4'b0110);
  clear_switches();
endtask

task automatic test_lang_card();
  byte_t got;
  io_read(8'h83, got);
  compare_value("lc_we", lc_we, 1'b0);  // armed only
  io_read(8'h83, got);
  compare_value("lc_we", lc_we, 1'b1);
  compare_value("lcram2", lcram2, 1'b1);
  compare_value("rdrom", rdrom, 1'b0);
  map_check({BANK_E0, 16'hD123}, 1'b1, {BANK_E0, 16'hC123});
  map_check({BANK_E1, 16'hD123}, 1'b1, {BANK_E1, 16'hC123});
  map_check({BANK_00, 16'hD123}, 1'b1, {BANK_00, 16'hC123});  // shadow bit 6 clear
  map_check({8'h02, 16'hD123}, 1'b1, {8'h02, 16'hD123});
  io_read(8'h82, got);
  compare_value("lc_we", lc_we, 1'b0);
  compare_value("rdrom", rdrom, 1'b1);
  map_check({BANK_E0, 16'hD123}, 1'b1, {BANK_E0, 16'hD123});
  io_read(8'h8B, got);  // bank 1 RAM
  compare_value("lcram2", lcram2, 1'b0);
  map_check({BANK_E0, 16'hD123}, 1'b1, {BANK_E0, 16'hD123});
  io_read(8'h81, got);
  compare_value("rdrom", rdrom, 1'b1);
  map_check({BANK_00, 16'hD123}, 1'b1, {BANK_00, 16'hD123});
endtask

task automatic test_interrupts();
  byte_t got;
  io_write(VGCINT, 8'h02);
  pulse_irq(4'b1000);
  compare_value("cpu_irq", cpu_irq, 1'b1);
  read_expect(VGCINT, 8'hA2);
  io_write(VGC_CLEAR, 8'h00);
  compare_value("cpu_irq", cpu_irq, 1'b0);
  read_expect(VGCINT, 8'h02);
  io_write(INTEN, 8'h08);
  pulse_irq(4'b0001);
  compare_value("cpu_irq", cpu_irq, 1'b1);
  read_expect(INTFLAG, 8'h09);  // bit 0 one cycle behind bit 3
  io_read(INT_CLEAR, got);
  compare_value("cpu_irq", cpu_irq, 1'b0);
  read_expect(INTFLAG, 8'h00);
  pulse_irq(4'b0110);  // both enables clear
  compare_value("cpu_irq", cpu_irq, 1'b0);
  read_expect(INTFLAG, 8'h00);
endtask

`endif

// ==== tests/tb_iigs_glue.sv ====
`timescale 1ns/1ps

module tb_iigs_glue;
  import iigs_pkg::*;

  localparam int        RESET_CYCLES   = 16;
  localparam int        TEST_CYCLES    = 220;  // sum over all directed tests, rounded up
  localparam int        TIMEOUT_CYCLES = RESET_CYCLES + 2 * TEST_CYCLES;
  localparam cpu_addr_t IDLE_ADDR      = 24'h02_0000;  // outside the I/O page

  logic      clk_sys;
  logic      cpu_vda;
  logic      cpu_ce;
  logic      cpu_rd;
  cpu_addr_t cpu_addr;
  byte_t     cpu_dout;
  byte_t     din;
  logic      vblank;
  logic      scanline_irq;
  logic      onesecond_irq;
  logic      qtrsecond_irq;
  logic      vbl_irq;
  cpu_addr_t bus_addr;
  byte_t     cpu_din;
  logic      io;
  logic      cpu_irq;
  byte_t     shadow;
  byte_t     newvideo;
  byte_t     textcolor;
  logic      textg;
  logic      mixg;
  logic      page2;
  logic      hires_mode;
  logic      rdrom;
  logic      lcram2;
  logic      lc_we;

  logic [31:0] rng_state;
  int          cycle_count = 0;

  iigs_glue u_dut (
    .clk_sys       (clk_sys),
    .cpu_vda       (cpu_vda),
    .cpu_ce        (cpu_ce),
    .cpu_rd        (cpu_rd),
    .cpu_addr      (cpu_addr),
    .cpu_dout      (cpu_dout),
    .din           (din),
    .vblank        (vblank),
    .scanline_irq  (scanline_irq),
    .onesecond_irq (onesecond_irq),
    .qtrsecond_irq (qtrsecond_irq),
    .vbl_irq       (vbl_irq),
    .bus_addr      (bus_addr),
    .cpu_din       (cpu_din),
    .io            (io),
    .cpu_irq       (cpu_irq),
    .shadow        (shadow),
    .newvideo      (newvideo),
    .textcolor     (textcolor),
    .textg         (textg),
    .mixg          (mixg),
    .page2         (page2),
    .hires_mode    (hires_mode),
    .rdrom         (rdrom),
    .lcram2        (lcram2),
    .lc_we         (lc_we)
  );

  always #50 clk_sys = ~clk_sys;

  always @(posedge clk_sys) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  `include "glue_tests.svh"

  initial begin
    clk_sys       = 1'b0;
    cpu_vda       = 1'b1;
    cpu_ce        = 1'b0;
    cpu_rd        = 1'b1;
    cpu_addr      = IDLE_ADDR;
    cpu_dout      = 8'h00;
    din           = 8'h5A;  // memory data, never seen on I/O reads
    vblank        = 1'b0;
    scanline_irq  = 1'b0;
    onesecond_irq = 1'b0;
    qtrsecond_irq = 1'b0;
    vbl_irq       = 1'b0;
    rng_state     = 32'h92ca;
    repeat (RESET_CYCLES) @(posedge clk_sys);
    #1;
    cpu_vda = 1'b0;
    test_reset_defaults();
    test_switches();
    test_aux_map();
    test_lang_card();
    test_interrupts();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== logic/iigs_glue.sv ====
`timescale 1ns/1ps

module iigs_glue #(
  parameter iigs_pkg::byte_t SHADOW_RST    = iigs_pkg::SHADOW_RST,
  parameter iigs_pkg::byte_t NEWVIDEO_RST  = iigs_pkg::NEWVIDEO_RST,
  parameter iigs_pkg::byte_t TEXTCOLOR_RST = iigs_pkg::TEXTCOLOR_RST
) (
  input  logic                clk_sys,
  input  logic                cpu_vda,
  input  logic                cpu_ce,
  input  logic                cpu_rd,
  input  iigs_pkg::cpu_addr_t cpu_addr,
  input  iigs_pkg::byte_t     cpu_dout,
  input  iigs_pkg::byte_t     din,
  input  logic                vblank,
  input  logic                scanline_irq,
  input  logic                onesecond_irq,
  input  logic                qtrsecond_irq,
  input  logic                vbl_irq,
  output iigs_pkg::cpu_addr_t bus_addr,
  output iigs_pkg::byte_t     cpu_din,
  output logic                io,
  output logic                cpu_irq,
  output iigs_pkg::byte_t     shadow,
  output iigs_pkg::byte_t     newvideo,
  output iigs_pkg::byte_t     textcolor,
  output logic                textg,
  output logic                mixg,
  output logic                page2,
  output logic                hires_mode,
  output logic                rdrom,
  output logic                lcram2,
  output logic                lc_we
);
  import iigs_pkg::*;

  logic    io_rd;
  logic    io_wr;
  io_reg_t io_reg;
  byte_t   ss_rdata;
  byte_t   irq_rdata;
  logic    store80;
  logic    ramrd;
  logic    ramwrt;
  logic    altzp;

  bus_map u_bus_map (
    .clk_sys    (clk_sys),
    .cpu_vda    (cpu_vda),
    .cpu_ce     (cpu_ce),
    .cpu_rd     (cpu_rd),
    .cpu_addr   (cpu_addr),
    .din        (din),
    .ss_rdata   (ss_rdata),
    .irq_rdata  (irq_rdata),
    .store80    (store80),
    .ramrd      (ramrd),
    .ramwrt     (ramwrt),
    .altzp      (altzp),
    .page2      (page2),
    .hires_mode (hires_mode),
    .lcram2     (lcram2),
    .rdrom      (rdrom),
    .shadow     (shadow),
    .io         (io),
    .io_rd      (io_rd),
    .io_wr      (io_wr),
    .io_reg     (io_reg),
    .bus_addr   (bus_addr),
    .cpu_din    (cpu_din)
  );

  soft_switches #(
    .SHADOW_RST    (SHADOW_RST),
    .NEWVIDEO_RST  (NEWVIDEO_RST),
    .TEXTCOLOR_RST (TEXTCOLOR_RST)
  ) u_soft_switches (
    .clk_sys    (clk_sys),
    .cpu_vda    (cpu_vda),
    .io_rd      (io_rd),
    .io_wr      (io_wr),
    .io_reg     (io_reg),
    .cpu_dout   (cpu_dout),
    .vblank     (vblank),
    .store80    (store80),
    .ramrd      (ramrd),
    .ramwrt     (ramwrt),
    .altzp      (altzp),
    .page2      (page2),
    .hires_mode (hires_mode),
    .lcram2     (lcram2),
    .rdrom      (rdrom),
    .shadow     (shadow),
    .ss_rdata   (ss_rdata),
    .textg      (textg),
    .mixg       (mixg),
    .newvideo   (newvideo),
    .textcolor  (textcolor),
    .lc_we      (lc_we)
  );

  irq_ctrl u_irq_ctrl (
    .clk_sys       (clk_sys),
    .cpu_vda       (cpu_vda),
    .io_rd         (io_rd),
    .io_wr         (io_wr),
    .io_reg        (io_reg),
    .cpu_dout      (cpu_dout),
    .scanline_irq  (scanline_irq),
    .onesecond_irq (onesecond_irq),
    .qtrsecond_irq (qtrsecond_irq),
    .vbl_irq       (vbl_irq),
    .irq_rdata     (irq_rdata),
    .cpu_irq       (cpu_irq)
  );

endmodule

// ==== logic/irq_ctrl.sv ====
`timescale 1ns/1ps

module irq_ctrl (
  input  logic              clk_sys,
  input  logic              cpu_vda,
  input  logic              io_rd,
  input  logic              io_wr,
  input  iigs_pkg::io_reg_t io_reg,
  input  iigs_pkg::byte_t   cpu_dout,
  input  logic              scanline_irq,
  input  logic              onesecond_irq,
  input  logic              qtrsecond_irq,
  input  logic              vbl_irq,
  output iigs_pkg::byte_t   irq_rdata,
  output logic              cpu_irq
);
  import iigs_pkg::*;

  logic [2:1] vgc_en;    // 2 one-second, 1 scanline
  logic       vgc_scan;  // VGCINT bit 5
  logic       vgc_sec;   // VGCINT bit 6
  logic       vgc_any;   // VGCINT bit 7
  logic [4:0] inten;
  logic       flag_vbl;  // INTFLAG bit 3
  logic       flag_qtr;  // INTFLAG bit 4
  logic       flag_any;  // INTFLAG bit 0, one cycle behind

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      vgc_en   <= '0;
      vgc_scan <= 1'b0;
      vgc_sec  <= 1'b0;
      vgc_any  <= 1'b0;
      inten    <= '0;
      flag_vbl <= 1'b0;
      flag_qtr <= 1'b0;
      flag_any <= 1'b0;
    end else begin
      if (io_wr && io_reg == VGCINT) begin
        vgc_en <= cpu_dout[2:1];  // status bits are read only
      end
      if (io_wr && io_reg == VGC_CLEAR) begin
        if (!cpu_dout[5]) vgc_scan <= 1'b0;
        if (!cpu_dout[6]) vgc_sec <= 1'b0;
        if ((!vgc_scan || !cpu_dout[5]) && (!vgc_sec || !cpu_dout[6])) begin
          vgc_any <= 1'b0;
        end
      end
      if (io_wr && io_reg == INTEN) begin
        inten <= cpu_dout[4:0];
      end
      if ((io_rd || io_wr) && io_reg == INT_CLEAR) begin
        flag_vbl <= 1'b0;
        flag_qtr <= 1'b0;
      end
      // a source pulse beats a clear in the same cycle
      if (scanline_irq) begin
        vgc_scan <= 1'b1;  // status sets even when disabled
        if (vgc_en[1]) vgc_any <= 1'b1;
      end
      if (onesecond_irq && vgc_en[2]) begin
        vgc_sec <= 1'b1;
        vgc_any <= 1'b1;
      end
      if (vbl_irq && inten[3]) flag_vbl <= 1'b1;
      if (qtrsecond_irq && inten[4]) flag_qtr <= 1'b1;
      flag_any <= flag_vbl | flag_qtr | vgc_sec | vgc_any;
    end
  end

  always_comb begin
    case (io_reg)
      VGCINT:  irq_rdata = {vgc_any, vgc_sec, vgc_scan, 2'b00, vgc_en, 1'b0};
      INTEN:   irq_rdata = {3'b000, inten};
      INTFLAG: irq_rdata = {3'b000, flag_qtr, flag_vbl, 2'b00, flag_any};
      default: irq_rdata = '0;
    endcase
  end

  assign cpu_irq = (vgc_scan & vgc_en[1]) | (vgc_sec & vgc_en[2]) |
                   (flag_vbl & inten[3]) | (flag_qtr & inten[4]);

endmodule

// ==== logic/soft_switches.sv ====
`timescale 1ns/1ps

module soft_switches #(
  parameter iigs_pkg::byte_t SHADOW_RST    = iigs_pkg::SHADOW_RST,
  parameter iigs_pkg::byte_t NEWVIDEO_RST  = iigs_pkg::NEWVIDEO_RST,
  parameter iigs_pkg::byte_t TEXTCOLOR_RST = iigs_pkg::TEXTCOLOR_RST
) (
  input  logic              clk_sys,
  input  logic              cpu_vda,
  input  logic              io_rd,
  input  logic              io_wr,
  input  iigs_pkg::io_reg_t io_reg,
  input  iigs_pkg::byte_t   cpu_dout,
  input  logic              vblank,
  output logic              store80,
  output logic              ramrd,
  output logic              ramwrt,
  output logic              altzp,
  output logic              page2,
  output logic              hires_mode,
  output logic              lcram2,
  output logic              rdrom,
  output iigs_pkg::byte_t   shadow,
  output iigs_pkg::byte_t   ss_rdata,
  output logic              textg,
  output logic              mixg,
  output iigs_pkg::byte_t   newvideo,
  output iigs_pkg::byte_t   textcolor,
  output logic              lc_we
);
  import iigs_pkg::*;

  // bit positions follow the C000-C00F pair order
  localparam int SW_STORE80  = 0;
  localparam int SW_RAMRD    = 1;
  localparam int SW_RAMWRT   = 2;
  localparam int SW_INTCXROM = 3;
  localparam int SW_ALTZP    = 4;
  localparam int SW_SLOTC3   = 5;
  localparam int SW_80COL    = 6;
  localparam int SW_ALTCHAR  = 7;
  localparam int VID_TEXT    = 0;
  localparam int VID_MIX     = 1;
  localparam int VID_PAGE2   = 2;
  localparam int VID_HIRES   = 3;

  logic [7:0]  mem_sw;
  logic [3:0]  vid_sw;
  lc_wr_e      lc_state;
  logic [15:1] status;  // C011-C01F flags, indexed by low nibble

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      mem_sw    <= '0;
      vid_sw    <= '0;
      rdrom     <= 1'b1;
      lcram2    <= 1'b0;
      lc_state  <= LC_WR_OFF;
      shadow    <= SHADOW_RST;
      newvideo  <= NEWVIDEO_RST;
      textcolor <= TEXTCOLOR_RST;
    end else if (io_rd || io_wr) begin
      if (io_reg <= ALTCHAR_ON) begin
        // reads only touch the RAMRD/RAMWRT pairs
        if (io_wr || (io_reg >= RAMRD_OFF && io_reg <= RAMWRT_ON)) begin
          mem_sw[io_reg[3:1]] <= io_reg[0];
        end
      end
      if (io_reg >= TXT_CLR && io_reg <= HIRES_SET) begin
        vid_sw[io_reg[2:1]] <= io_reg[0];
      end
      if (io_reg >= LC_BASE && io_reg <= LC_LAST) begin
        rdrom  <= io_reg[0] ^ io_reg[1];  // 1 and 2 read ROM
        lcram2 <= ~io_reg[3];
        if (io_rd && io_reg[0]) begin
          if (lc_state == LC_WR_OFF) begin
            lc_state <= LC_WR_ARMED;
          end else begin
            lc_state <= LC_WR_ON;
          end
        end else begin
          lc_state <= LC_WR_OFF;
        end
      end
      if (io_wr) begin
        case (io_reg)
          TEXTCOLOR: textcolor <= cpu_dout;
          NEWVIDEO:  newvideo  <= cpu_dout;
          SHADOW:    shadow    <= cpu_dout;
          STATEREG: begin
            mem_sw[SW_ALTZP]    <= cpu_dout[7];
            vid_sw[VID_PAGE2]   <= cpu_dout[6];
            mem_sw[SW_RAMRD]    <= cpu_dout[5];
            mem_sw[SW_RAMWRT]   <= cpu_dout[4];
            rdrom               <= cpu_dout[3];
            lcram2              <= cpu_dout[2];
            mem_sw[SW_INTCXROM] <= cpu_dout[0];  // bit 1 was ROMBANK
          end
          default: ;
        endcase
      end
    end
  end

  assign store80    = mem_sw[SW_STORE80];
  assign ramrd      = mem_sw[SW_RAMRD];
  assign ramwrt     = mem_sw[SW_RAMWRT];
  assign altzp      = mem_sw[SW_ALTZP];
  assign textg      = vid_sw[VID_TEXT];
  assign mixg       = vid_sw[VID_MIX];
  assign page2      = vid_sw[VID_PAGE2];
  assign hires_mode = vid_sw[VID_HIRES];
  assign lc_we      = (lc_state == LC_WR_ON);

  assign status = {mem_sw[SW_80COL], mem_sw[SW_ALTCHAR], hires_mode, page2, mixg, textg,
                   ~vblank, store80, mem_sw[SW_SLOTC3], altzp, mem_sw[SW_INTCXROM],
                   ramwrt, ramrd, ~rdrom, lcram2};

  always_comb begin
    ss_rdata = '0;
    if (io_reg >= RD_LCBNK2 && io_reg <= RD_80COL) begin
      ss_rdata = {status[io_reg[3:0]], 7'b0};  // keyboard bits are gone
    end else begin
      case (io_reg)
        TEXTCOLOR: ss_rdata = textcolor;
        NEWVIDEO:  ss_rdata = newvideo;
        SHADOW:    ss_rdata = shadow;
        STATEREG:  ss_rdata = {altzp, page2, ramrd, ramwrt, rdrom, lcram2, 1'b0,
                               mem_sw[SW_INTCXROM]};
        default:   ss_rdata = '0;
      endcase
    end
  end

endmodule

// ==== logic/bus_map.sv ====
`timescale 1ns/1ps

module bus_map (
  input  logic                clk_sys,
  input  logic                cpu_vda,
  input  logic                cpu_ce,
  input  logic                cpu_rd,
  input  iigs_pkg::cpu_addr_t cpu_addr,
  input  iigs_pkg::byte_t     din,
  input  iigs_pkg::byte_t     ss_rdata,
  input  iigs_pkg::byte_t     irq_rdata,
  input  logic                store80,
  input  logic                ramrd,
  input  logic                ramwrt,
  input  logic                altzp,
  input  logic                page2,
  input  logic                hires_mode,
  input  logic                lcram2,
  input  logic                rdrom,
  input  iigs_pkg::byte_t     shadow,
  output logic                io,
  output logic                io_rd,
  output logic                io_wr,
  output iigs_pkg::io_reg_t   io_reg,
  output iigs_pkg::cpu_addr_t bus_addr,
  output iigs_pkg::byte_t     cpu_din
);
  import iigs_pkg::*;

  localparam cpu_addr_t LC_BANK2_DELTA = 24'h00_1000;  // D000-DFFF down to C000-CFFF

  bank_t       bank;
  logic [15:0] ofs;
  logic        main_bank;
  logic        e_bank;
  logic        aux_bank;
  logic        mode_aux;
  logic        aux;
  logic        lc_hit;
  byte_t       io_dout;

  assign bank = cpu_addr[23:16];
  assign ofs  = cpu_addr[15:0];

  assign main_bank = (bank == BANK_00) || (bank == BANK_01);
  assign e_bank    = (bank == BANK_E0) || (bank == BANK_E1);
  assign aux_bank  = (bank == BANK_00) || (bank == BANK_E0);

  // I/O page disappears when shadow bit 6 is set
  assign io     = (main_bank || e_bank) && !shadow[6] && (ofs[15:8] == 8'hC0);
  assign io_rd  = cpu_ce && io && cpu_rd;
  assign io_wr  = cpu_ce && io && !cpu_rd;
  assign io_reg = ofs[7:0];

  always_comb begin
    mode_aux = cpu_rd ? ramrd : ramwrt;
    if (!aux_bank) begin
      aux = 1'b0;
    end else if ((ofs[15:9] == 7'h00) || (ofs[15:14] == 2'b11)) begin
      aux = altzp;  // zero page, stack, C000-FFFF
    end else if (ofs[15:10] == 6'b00_0001) begin
      aux = store80 ? page2 : mode_aux;  // text page 1
    end else if (ofs[15:13] == 3'b001) begin
      aux = (store80 && hires_mode) ? page2 : mode_aux;  // hires page 1
    end else begin
      aux = mode_aux;
    end
  end

  // bank 2 of the language card lives under C000 in RAM;
  // in banks 00/01 only while the I/O page is shadowed in
  assign lc_hit = lcram2 && !rdrom && (ofs[15:12] == 4'hD) &&
                  (e_bank || (main_bank && !shadow[6]));

  always_comb begin
    bus_addr = cpu_addr;
    if (aux) begin
      bus_addr = bus_addr + AUX_OFFSET;
    end
    if (lc_hit) begin
      bus_addr = bus_addr - LC_BANK2_DELTA;
    end
  end

  // side blocks return zero for offsets they do not own
  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      io_dout <= '0;
    end else if (io_rd) begin
      io_dout <= ss_rdata | irq_rdata;
    end
  end

  assign cpu_din = io ? io_dout : din;

endmodule

// ==== logic/iigs_pkg.sv ====
package iigs_pkg;

  localparam int ADDR_W = 24;  // 65C816 bank plus 16-bit offset
  localparam int DATA_W = 8;

  typedef logic [ADDR_W-1:0] cpu_addr_t;
  typedef logic [7:0]        bank_t;
  typedef logic [DATA_W-1:0] byte_t;
  typedef logic [7:0]        io_reg_t;  // offset inside the C0xx page

  // soft-switch offsets of the I/O page that this glue still answers
  typedef enum io_reg_t {
    STORE80_OFF  = 8'h00,
    STORE80_ON   = 8'h01,
    RAMRD_OFF    = 8'h02,
    RAMRD_ON     = 8'h03,
    RAMWRT_OFF   = 8'h04,
    RAMWRT_ON    = 8'h05,
    INTCXROM_OFF = 8'h06,
    INTCXROM_ON  = 8'h07,
    ALTZP_OFF    = 8'h08,
    ALTZP_ON     = 8'h09,
    SLOTC3_OFF   = 8'h0A,
    SLOTC3_ON    = 8'h0B,
    COL80_OFF    = 8'h0C,
    COL80_ON     = 8'h0D,
    ALTCHAR_OFF  = 8'h0E,
    ALTCHAR_ON   = 8'h0F,
    RD_LCBNK2    = 8'h11,  // first status flag
    RD_80COL     = 8'h1F,  // last status flag
    TEXTCOLOR    = 8'h22,
    VGCINT       = 8'h23,
    NEWVIDEO     = 8'h29,
    VGC_CLEAR    = 8'h32,
    SHADOW       = 8'h35,
    INTEN        = 8'h41,
    INTFLAG      = 8'h46,
    INT_CLEAR    = 8'h47,
    TXT_CLR      = 8'h50,
    TXT_SET      = 8'h51,
    MIX_CLR      = 8'h52,
    MIX_SET      = 8'h53,
    PAGE2_CLR    = 8'h54,
    PAGE2_SET    = 8'h55,
    HIRES_CLR    = 8'h56,
    HIRES_SET    = 8'h57,
    STATEREG     = 8'h68,
    LC_BASE      = 8'h80,
    LC_LAST      = 8'h8F
  } io_reg_e;

  // language card write enable needs two odd reads in a row
  typedef enum logic [1:0] {
    LC_WR_OFF,
    LC_WR_ARMED,
    LC_WR_ON
  } lc_wr_e;

  localparam bank_t     BANK_00    = 8'h00;
  localparam bank_t     BANK_01    = 8'h01;
  localparam bank_t     BANK_E0    = 8'hE0;
  localparam bank_t     BANK_E1    = 8'hE1;
  localparam cpu_addr_t AUX_OFFSET = 24'h01_0000;  // one bank up

  localparam byte_t SHADOW_RST    = 8'h08;
  localparam byte_t NEWVIDEO_RST  = 8'h41;
  localparam byte_t TEXTCOLOR_RST = 8'hF2;  // white on blue

endpackage
